// ==== hdl/video_pkg.sv ====
// ------------------------------
// raster timing constants, state codes and framebuffer types
// shared by every block of the video output path
// ------------------------------

package video_pkg;

  // ------------------------------
  // horizontal timing, 24 MHz clocks
  localparam int h_total  = 768;
  localparam int h_front  = 11;
  localparam int h_sync   = 56;
  localparam int h_back   = 61;
  localparam int h_active = h_total - h_front - h_sync - h_back;  // 640
  localparam int h_border = 64;               // left and right side each

  // ------------------------------
  // vertical timing, lines
  localparam int v_total   = 624;
  localparam int v_front   = 21;
  localparam int v_sync    = 5;
  localparam int v_back    = 22;
  localparam int v_border  = 32;              // top and bottom each
  localparam int v_picture = v_total - v_front - v_sync - v_back - 2 * v_border;

  // framebuffer geometry
  localparam int line_bytes = 64;
  localparam int col_w      = 6;
  localparam int row_w      = 8;
  localparam int fb_addr_w  = row_w + col_w;  // row in the upper bits
  localparam int cnt_w      = 10;             // phase timers, both machines

  // phase codes, horizontal machine
  localparam logic [1:0] hs_front  = 2'd0;
  localparam logic [1:0] hs_sync   = 2'd1;
  localparam logic [1:0] hs_back   = 2'd2;
  localparam logic [1:0] hs_active = 2'd3;

  // phase codes, vertical machine
  localparam logic [2:0] vs_front = 3'd0;
  localparam logic [2:0] vs_sync  = 3'd1;
  localparam logic [2:0] vs_back  = 3'd2;
  localparam logic [2:0] vs_top   = 3'd3;
  localparam logic [2:0] vs_pic   = 3'd4;
  localparam logic [2:0] vs_bot   = 3'd5;

  typedef logic [1:0] pix_t;                  // colour index

  // one framebuffer byte, read as hires or lores pixels
  typedef union packed {
    logic [7:0] mono;                         // 8 x 1 bit, leftmost in bit 7
    pix_t [3:0] color;                        // 4 x 2 bit, leftmost in [3]
  } fb_byte_u;

endpackage

// ==== hdl/line_wr_if.sv ====
// ------------------------------
// line buffer write port, fetcher to buffer
// one byte per cycle while wr_en is high, no handshake
// ------------------------------
`timescale 1ns/1ns

interface line_wr_if;

  import video_pkg::*;

  logic             wr_en;      // write strobe
  logic [col_w-1:0] wr_col;     // byte column in the line
  fb_byte_u         wr_data;    // byte from the framebuffer

  // fetcher side
  modport source (
    output wr_en,
    output wr_col,
    output wr_data
  );

  // buffer side
  modport sink (
    input wr_en,
    input wr_col,
    input wr_data
  );

endinterface

// ==== hdl/raster_timing.sv ====
// ------------------------------
// raster generator, 768 clocks x 624 lines
// makes syncs, display and picture enables, and the fetch strobe with its row
// ------------------------------
`timescale 1ns/1ns

module raster_timing (
  input  logic                    clk24,
  input  logic                    rst_n,
  input  logic [video_pkg::row_w-1:0] scroll,
  output logic                    hsync_raw,
  output logic                    vsync_raw,
  output logic                    de,
  output logic                    pic,
  output logic                    fetch_start,
  output logic [video_pkg::row_w-1:0] fetch_row
);

  import video_pkg::*;

  logic [1:0]       h_st;       // horizontal phase
  logic [cnt_w-1:0] h_cnt;      // clocks left in phase, minus one
  logic [2:0]       v_st;       // vertical phase
  logic [cnt_w-1:0] v_cnt;      // lines left in phase, minus one
  logic [row_w:0]   row_q;      // scrolled row, one extra low bit for line doubling
  logic             line_first; // first clock of a line
  logic             line_end;   // last clock of a line
  logic             fetch_line; // next line is a picture line

  assign line_first = (h_st == hs_front) && (h_cnt == cnt_w'(h_front - 1));
  assign line_end   = (h_st == hs_active) && (h_cnt == '0);

  // ------------------------------
  // horizontal machine
  // front porch, sync, back porch, active
  always_ff @(posedge clk24 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      h_st  <= hs_front;
      h_cnt <= cnt_w'(h_front - 1);
    end
    else if (h_cnt != '0)
      h_cnt <= h_cnt - 1'b1;
    else
    begin
      case (h_st)
        hs_front:
        begin
          h_st  <= hs_sync;
          h_cnt <= cnt_w'(h_sync - 1);
        end
        hs_sync:
        begin
          h_st  <= hs_back;
          h_cnt <= cnt_w'(h_back - 1);
        end
        hs_back:
        begin
          h_st  <= hs_active;
          h_cnt <= cnt_w'(h_active - 1);
        end
        default:                                // end of line
        begin
          h_st  <= hs_front;
          h_cnt <= cnt_w'(h_front - 1);
        end
      endcase
    end
  end

  // ------------------------------
  // vertical machine, one step per line
  // new phase is visible from the first clock of the next line
  always_ff @(posedge clk24 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      v_st  <= vs_front;
      v_cnt <= cnt_w'(v_front - 1);
    end
    else if (line_end)
    begin
      if (v_cnt != '0)
        v_cnt <= v_cnt - 1'b1;
      else
      begin
        case (v_st)
          vs_front:
          begin
            v_st  <= vs_sync;
            v_cnt <= cnt_w'(v_sync - 1);
          end
          vs_sync:
          begin
            v_st  <= vs_back;
            v_cnt <= cnt_w'(v_back - 1);
          end
          vs_back:
          begin
            v_st  <= vs_top;
            v_cnt <= cnt_w'(v_border - 1);
          end
          vs_top:
          begin
            v_st  <= vs_pic;
            v_cnt <= cnt_w'(v_picture - 1);
          end
          vs_pic:
          begin
            v_st  <= vs_bot;
            v_cnt <= cnt_w'(v_border - 1);
          end
          default:                              // bottom border done, new frame
          begin
            v_st  <= vs_front;
            v_cnt <= cnt_w'(v_front - 1);
          end
        endcase
      end
    end
  end

  // scroll row counter
  // loaded entering the last top border line, so a scroll write
  // during the picture only shows in the next frame
  always_ff @(posedge clk24 or negedge rst_n)
  begin
    if (!rst_n)
      row_q <= '0;
    else if (line_end)
    begin
      if (v_st == vs_top && v_cnt == cnt_w'(1))
        row_q <= {scroll, 1'b1};            // 2*scroll+1 gives scroll twice
      else
        row_q <= row_q - 1'b1;              // wraps mod 512, row mod 256
    end
  end

  // last top border line and all picture lines but the last fetch ahead
  assign fetch_line  = (v_st == vs_top && v_cnt == '0) || (v_st == vs_pic && v_cnt != '0);
  assign fetch_start = line_first && fetch_line;
  assign fetch_row   = row_q[row_w:1];

  // ------------------------------
  // raw sync and enable levels
  assign hsync_raw = !(h_st == hs_sync);
  assign vsync_raw = !(v_st == vs_sync);
  assign de  = (h_st == hs_active) && (v_st == vs_top || v_st == vs_pic || v_st == vs_bot);
  assign pic = (h_st == hs_active) && (v_st == vs_pic) &&
               (h_cnt >= cnt_w'(h_border)) && (h_cnt < cnt_w'(h_active - h_border));

endmodule

// ==== hdl/line_fetch.sv ====
// ------------------------------
// framebuffer reader, 64 bytes per fetch strobe
// each returned byte goes to the line buffer one cycle after its read
// ------------------------------
`timescale 1ns/1ns

module line_fetch (
  input  logic                        clk24,
  input  logic                        rst_n,
  input  logic                        fetch_start,
  input  logic [video_pkg::row_w-1:0] fetch_row,
  output logic                        fb_rd,
  output logic [video_pkg::fb_addr_w-1:0] fb_addr,
  input  logic [7:0]                  fb_data,
  line_wr_if.source                   wr
);

  import video_pkg::*;

  logic [row_w-1:0] row;        // row of the line being fetched
  logic [col_w-1:0] col;        // column of the current read

  // ------------------------------
  // read sequencer
  // fb_rd stays high for exactly line_bytes cycles
  always_ff @(posedge clk24 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      fb_rd <= 1'b0;
      row   <= '0;
      col   <= '0;
    end
    else if (fetch_start)
    begin
      fb_rd <= 1'b1;
      row   <= fetch_row;                   // held for the whole line
      col   <= '0;
    end
    else if (fb_rd)
    begin
      col <= col + 1'b1;
      if (col == col_w'(line_bytes - 1))
        fb_rd <= 1'b0;                      // last column issued
    end
  end

  assign fb_addr = {row, col};              // row then column

  // ------------------------------
  // write stage, one cycle behind the reads
  always_ff @(posedge clk24 or negedge rst_n)
  begin
    if (!rst_n)
      wr.wr_en <= 1'b0;
    else
      wr.wr_en <= fb_rd;                    // data is back this cycle
  end

  always_ff @(posedge clk24)
  begin
    wr.wr_col <= col;                       // column issued last cycle
  end

  assign wr.wr_data = fb_data;              // memory answers in one cycle

endmodule

// ==== hdl/line_buffer.sv ====
// ------------------------------
// two bank line store, one line shown while the next one loads
// bank swaps on every fetch strobe
// ------------------------------
`timescale 1ns/1ns

module line_buffer (
  input  logic                        clk24,
  input  logic                        rst_n,
  input  logic                        fetch_start,
  line_wr_if.sink                     wr,
  input  logic [video_pkg::col_w-1:0] rd_col,
  output video_pkg::fb_byte_u         rd_data
);

  import video_pkg::*;

  logic     wr_bank;                      // bank the fetcher fills
  fb_byte_u mem [0:1][0:line_bytes-1];    // ping-pong storage

  // ------------------------------
  // bank select
  always_ff @(posedge clk24 or negedge rst_n)
  begin
    if (!rst_n)
      wr_bank <= 1'b0;
    else if (fetch_start)
      wr_bank <= ~wr_bank;                // new line goes to the other bank
  end

  // ------------------------------
  // write side
  always_ff @(posedge clk24)
  begin
    if (wr.wr_en)
      mem[wr_bank][wr.wr_col] <= wr.wr_data;
  end

  // read side, combinational from the bank not being filled
  // holds the line loaded during the previous line time
  assign rd_data = mem[~wr_bank][rd_col];

endmodule

// ==== hdl/pixel_shift.sv ====
// ------------------------------
// byte serializer and output register
// hires or lores decode, border fill, syncs delayed to match
// ------------------------------
`timescale 1ns/1ns

module pixel_shift (
  input  logic                        clk24,
  input  logic                        rst_n,
  input  logic                        hires,
  input  video_pkg::pix_t             border_color,
  input  logic                        de,
  input  logic                        pic,
  input  logic                        hsync_raw,
  input  logic                        vsync_raw,
  output logic [video_pkg::col_w-1:0] rd_col,
  input  video_pkg::fb_byte_u         rd_data,
  output video_pkg::pix_t             pix,
  output logic                        de_out,
  output logic                        hsync,
  output logic                        vsync
);

  import video_pkg::*;

  logic [col_w+2:0] px_cnt;     // clock index inside the picture, 0..511
  logic [2:0]       slot;       // clock within the current byte
  pix_t             pic_pix;    // decoded picture pixel

  // pixel counter, cleared in every clock outside the picture
  always_ff @(posedge clk24 or negedge rst_n)
  begin
    if (!rst_n)
      px_cnt <= '0;
    else if (pic)
      px_cnt <= px_cnt + 1'b1;
    else
      px_cnt <= '0;
  end

  assign rd_col = px_cnt[col_w+2:3];        // 8 clocks per byte
  assign slot   = px_cnt[2:0];

  // ------------------------------
  // decode, leftmost pixel first
  assign pic_pix = hires ? {1'b0, rd_data.mono[~slot]}   // 1 bit per clock
                         : rd_data.color[~slot[2:1]];    // 2 bits held 2 clocks

  // output stage, one clock behind the raw timing
  always_ff @(posedge clk24 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pix    <= '0;
      de_out <= 1'b0;
      hsync  <= 1'b1;
      vsync  <= 1'b1;
    end
    else
    begin
      pix    <= !de ? pix_t'(0) : (pic ? pic_pix : border_color);
      de_out <= de;
      hsync  <= hsync_raw;
      vsync  <= vsync_raw;
    end
  end

endmodule

// ==== hdl/video_top.sv ====
// ------------------------------
// video output top level
// raster timing, line fetch, line buffer and pixel stage
// ------------------------------
`timescale 1ns/1ns

module video_top (
  input  logic                            clk24,
  input  logic                            rst_n,
  input  logic [video_pkg::row_w-1:0]     scroll,       // first picture row
  input  logic                            hires,        // 1 = 8 mono pixels per byte
  input  video_pkg::pix_t                 border_color,
  output logic                            fb_rd,
  output logic [video_pkg::fb_addr_w-1:0] fb_addr,
  input  logic [7:0]                      fb_data,      // valid 1 clock after fb_rd
  output logic                            hsync,
  output logic                            vsync,
  output logic                            de,
  output video_pkg::pix_t                 pix
);

  import video_pkg::*;

  logic             hsync_raw;
  logic             vsync_raw;
  logic             de_raw;      // display area, before the output register
  logic             pic;
  logic             fetch_start;
  logic [row_w-1:0] fetch_row;
  logic [col_w-1:0] rd_col;
  fb_byte_u         rd_data;

  line_wr_if u_wr ();            // fetcher to buffer writes

  raster_timing u_timing (
    .clk24(clk24), .rst_n(rst_n), .scroll(scroll),
    .hsync_raw(hsync_raw), .vsync_raw(vsync_raw), .de(de_raw), .pic(pic),
    .fetch_start(fetch_start), .fetch_row(fetch_row)
  );

  line_fetch u_fetch (
    .clk24(clk24), .rst_n(rst_n), .fetch_start(fetch_start), .fetch_row(fetch_row),
    .fb_rd(fb_rd), .fb_addr(fb_addr), .fb_data(fb_data), .wr(u_wr.source)
  );

  line_buffer u_buffer (
    .clk24(clk24), .rst_n(rst_n), .fetch_start(fetch_start), .wr(u_wr.sink),
    .rd_col(rd_col), .rd_data(rd_data)
  );

  pixel_shift u_pixel (
    .clk24(clk24), .rst_n(rst_n), .hires(hires), .border_color(border_color),
    .de(de_raw), .pic(pic), .hsync_raw(hsync_raw), .vsync_raw(vsync_raw),
    .rd_col(rd_col), .rd_data(rd_data),
    .pix(pix), .de_out(de), .hsync(hsync), .vsync(vsync)
  );

endmodule

// ==== bench/video_tb.sv ====
// ------------------------------
// directed testbench for video_top with a framebuffer model and a pixel reference model
// checks syncs, enables, fetch addresses and every pixel of three frames
// ------------------------------
`timescale 1ns/1ns

module video_tb;

  import video_pkg::*;

  localparam int de_line0  = v_front + v_sync + v_back;        // top border starts on line 48
  localparam int pic_line0 = de_line0 + v_border;              // picture starts on line 80
  localparam int de_col0   = h_front + h_sync + h_back;         // 128
  localparam int pic_col0  = de_col0 + h_border;               // 192
  localparam int wait_max  = 700000;                           // more cycles than one frame

  logic                 clk24;
  logic                 rst_n;
  logic [row_w-1:0]     scroll;
  logic                 hires;
  pix_t                 border_color;
  logic                 fb_rd;
  logic [fb_addr_w-1:0] fb_addr;
  logic [7:0]           fb_data;
  logic [7:0]           pend_data;    // answer to the read seen last cycle
  logic                 hsync;
  logic                 vsync;
  logic                 de;
  pix_t                 pix;

  logic [7:0] key;                    // framebuffer content key
  logic [7:0] frame_scroll;           // scroll the model uses for this frame
  int         ln;                     // model line counted from the first front porch line
  int         cx;                     // model clock counted from the first front porch clock

  video_top u_dut (
    .clk24(clk24), .rst_n(rst_n), .scroll(scroll), .hires(hires),
    .border_color(border_color), .fb_rd(fb_rd), .fb_addr(fb_addr), .fb_data(fb_data),
    .hsync(hsync), .vsync(vsync), .de(de), .pix(pix)
  );

  initial
  begin
    clk24 = 1'b0;
    forever #5 clk24 = ~clk24;
  end

  // framebuffer byte is low address byte ^ high address bits ^ key
  function automatic logic [7:0] fb_byte(input logic [7:0] row, input int col);
    logic [fb_addr_w-1:0] a;
    begin
      a = {row, 6'(col)};
      return a[7:0] ^ {2'b00, a[13:8]} ^ key;
    end
  endfunction

  // ------------------------------
  // synchronous memory answering one clock after fb_rd
  always @(negedge clk24)
  begin
    fb_data   <= pend_data;
    pend_data <= fb_rd ? fb_byte(fb_addr[13:6], fb_addr[5:0]) : 8'h00;
  end

  task automatic fail_now();
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_pix(input string name, input pix_t exp, input pix_t act);
    if (exp !== act)
    begin
      $display("MISMATCH at %0t %s expected %0d actual %0d", $time, name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("MISMATCH at %0t %s expected %b actual %b", $time, name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_addr(input string name, input logic [fb_addr_w-1:0] exp,
                            input logic [fb_addr_w-1:0] act);
    if (exp !== act)
    begin
      $display("MISMATCH at %0t %s expected %h actual %h", $time, name, exp, act);
      fail_now();
    end
  endtask

  // ------------------------------
  // outputs idle during and after reset
  task automatic reset_idle();
    int n;
    for (n = 0; n < 4; n++)
    begin
      if (n == 1)
        rst_n = 1'b1;                          // released after 2 cycles
      check_bit("hsync", 1'b1, hsync);
      check_bit("vsync", 1'b1, vsync);
      check_bit("de", 1'b0, de);
      check_bit("fb_rd", 1'b0, fb_rd);
      check_pix("pix", 2'd0, pix);
      @(negedge clk24);
    end
  endtask

  // model counters start at the first falling vsync edge
  task automatic wait_vsync_fall();
    int  n;
    logic prev;
    prev = vsync;
    for (n = 0; n < wait_max; n++)
    begin
      @(negedge clk24);
      if (prev && !vsync)
        break;
      prev = vsync;
    end
    if (n == wait_max)
    begin
      $display("timeout, vsync never fell");
      fail_now();
    end
    ln = v_front;
    cx = 0;
  endtask

  // checks one frame clock by clock with an optional scroll write mid-picture
  task automatic run_frame(input bit change, input logic [7:0] new_scroll);
    int         n;
    int         x;
    int         s;
    bit         de_e;
    bit         pic_e;
    bit         rd_e;
    logic [7:0] b;
    logic [7:0] row;
    pix_t       p_e;
    for (n = 0; n < h_total * v_total; n++)
    begin
      if (ln == pic_line0 - 1 && cx == 0)
        frame_scroll = scroll;                 // scroll for this frame's picture
      de_e  = ln >= de_line0 && cx >= de_col0;
      pic_e = ln >= pic_line0 && ln < pic_line0 + v_picture &&
              cx >= pic_col0 && cx < pic_col0 + 512;
      rd_e  = ln >= pic_line0 - 1 && ln < pic_line0 + v_picture - 1 && cx < line_bytes;
      check_bit("hsync", !(cx >= h_front && cx < h_front + h_sync), hsync);
      check_bit("vsync", !(ln >= v_front && ln < v_front + v_sync), vsync);
      check_bit("de", de_e, de);
      check_bit("fb_rd", rd_e, fb_rd);
      if (rd_e)
      begin
        row = frame_scroll - 8'((ln - pic_line0 + 1) / 2);   // each row twice
        check_addr("fb_addr", {row, 6'(cx)}, fb_addr);
      end
      if (!de_e)
        p_e = 2'd0;
      else if (!pic_e)
        p_e = border_color;
      else
      begin
        x   = cx - pic_col0;
        s   = x % 8;
        row = frame_scroll - 8'((ln - pic_line0) / 2);
        b   = fb_byte(row, x / 8);
        p_e = hires ? {1'b0, b[7 - s]} : b[7 - 2 * (s / 2) -: 2];  // msb pixel first
      end
      check_pix("pix", p_e, pix);
      if (change && ln == 336 && cx == 0)
        scroll = new_scroll;
      cx++;
      if (cx == h_total)
      begin
        cx = 0;
        ln = (ln + 1) % v_total;
      end
      @(negedge clk24);
    end
  endtask

  // ------------------------------
  task automatic hires_frame();
    hires        = 1'b1;
    border_color = 2'd2;
    scroll       = 8'h03;
    run_frame(1'b0, 8'h00);
  endtask

  // new scroll only shows from the next frame
  task automatic scroll_change();
    run_frame(1'b1, 8'h00);
  endtask

  // rows wrap from 0 to 255 in this frame
  task automatic lores_frame();
    hires        = 1'b0;
    border_color = 2'd1;
    run_frame(1'b0, 8'h00);
  endtask

  initial
  begin
    rst_n        = 1'b0;
    scroll       = 8'h03;
    hires        = 1'b1;
    border_color = 2'd2;
    fb_data      = 8'h00;
    pend_data    = 8'h00;
    frame_scroll = 8'h00;
    ln           = 0;
    cx           = 0;
    key          = 8'($urandom(32'h6360_5a0b));
    @(posedge clk24);
    @(negedge clk24);                          // first falling edge of the running clock
    reset_idle();
    wait_vsync_fall();
    hires_frame();
    scroll_change();
    lores_frame();
    $display("test passed");
    $finish;
  end

endmodule

// ==== video_sys.f ====
hdl/video_pkg.sv
hdl/line_wr_if.sv
hdl/raster_timing.sv
hdl/line_fetch.sv
hdl/line_buffer.sv
hdl/pixel_shift.sv
hdl/video_top.sv
bench/video_tb.sv

// ==== Bender.yml ====
package:
  name: video_sys

sources:
  - hdl/video_pkg.sv
  - hdl/line_wr_if.sv
  - hdl/raster_timing.sv
  - hdl/line_fetch.sv
  - hdl/line_buffer.sv
  - hdl/pixel_shift.sv
  - hdl/video_top.sv
  - target: simulation
    files:
      - bench/video_tb.sv
